// File: vlog.f
verilog/ps2_pkg.sv
verilog/kbc_pkg.sv
verilog/ps2_rx.sv
verilog/kbc_host.sv
verilog/ps2_kbc.sv
bench/ps2_rx_props.sv
bench/tb_ps2_kbc.sv

// File: Bender.yml
package:
  name: ps2_kbc

sources:
  - verilog/ps2_pkg.sv
  - verilog/kbc_pkg.sv
  - verilog/ps2_rx.sv
  - verilog/kbc_host.sv
  - verilog/ps2_kbc.sv
  - target: test
    files:
      - bench/ps2_rx_props.sv
      - bench/tb_ps2_kbc.sv

// File: bench/tb_ps2_kbc.sv
// Self-checking testbench for the PS/2 controller with a byte model and line frame driver
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_kbc;

  localparam int NUM_FRAMES  = 9;    // Line frames sent over the run
  localparam int BUS_CYCLES  = 300;  // Bus accesses and waits with margin
  localparam int CYCLE_LIMIT = 3 * (NUM_FRAMES * 88 + BUS_CYCLES);

  logic                          wb_clk_i;
  logic                          wb_rst_i;
  logic [kbc_pkg::WB_DATA_W-1:0] wb_dat_i;
  logic [kbc_pkg::WB_DATA_W-1:0] wb_dat_o;
  logic                          wb_cyc_i, wb_stb_i, wb_we_i;
  logic [2:1]                    wb_adr_i;
  logic [1:0]                    wb_sel_i;
  logic                          wb_ack_o, wb_tgk_o, wb_tgm_o;
  logic                          ps2_kbd_clk_i, ps2_kbd_dat_i;
  logic                          ps2_mse_clk_i, ps2_mse_dat_i;

  // Model of what the controller holds
  logic [7:0] kbd_byte, mse_byte, ctrl_byte, last_cmd;
  logic       kbd_pend, mse_pend, err_flag;
  logic [7:0] exp_q[$];  // Expected data port bytes in read order
  logic [7:0] act_q[$];
  integer     seed = 32'h60a17e66;
  int         data_errors = 0;
  int         other_errors = 0;
  int         assert_errors;
  int         cycles = 0;

  ps2_kbc UUT (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic logic [7:0] expected_data();
    case (last_cmd)
      8'h20:   return ctrl_byte;
      8'hAA:   return 8'h55;
      8'hA9:   return 8'h00;
      default: return mse_pend ? mse_byte : kbd_byte;  // Mouse before keyboard
    endcase
  endfunction

  function automatic logic [7:0] expected_status();
    logic ibf;
    ibf = kbd_pend | mse_pend | (last_cmd inside {8'h20, 8'hAA, 8'hA9});
    return {err_flag, 1'b0, mse_pend, 1'b1, 1'b0, 1'b1, 1'b0, ibf};  // sys and inh high
  endfunction

  task automatic compare_value(input logic [7:0] act, input logic [7:0] exp, input string what);
    if (act !== exp) begin
      other_errors++;
      $display("[ERROR] %0t ns: %s read %02h, expected %02h", $time, what, act, exp);
    end
  endtask

  task automatic print_counts();
    assert_errors = UUT.u_kbd_rx.u_props.fails + UUT.u_mse_rx.u_props.fails;
    $display("Errors: %0d data read, %0d other, %0d assertion",
             data_errors, other_errors, assert_errors);
  endtask

  // ----------------------------------------------------------------------
  // Single-cycle Wishbone accesses
  // ----------------------------------------------------------------------
  task automatic bus_cycle(input logic we, input logic [2:1] adr, input logic [1:0] sel,
                           input logic [7:0] wbyte, output logic [7:0] rbyte);
    @(negedge wb_clk_i);
    {wb_cyc_i, wb_stb_i, wb_we_i} = {2'b11, we};
    wb_adr_i = adr;
    wb_sel_i = sel;
    wb_dat_i = sel[0] ? {8'h00, wbyte} : {wbyte, 8'h00};
    #5;  // Reply is combinational
    rbyte = sel[0] ? wb_dat_o[7:0] : wb_dat_o[15:8];
    if (wb_ack_o !== 1'b1) begin
      other_errors++;
      $display("[ERROR] %0t ns: bus access got no acknowledge", $time);
    end
    @(negedge wb_clk_i);
    {wb_cyc_i, wb_stb_i} = 2'b00;
  endtask

  task automatic write_port(input logic [2:1] adr, input logic [7:0] b);
    logic [7:0] unused;
    bus_cycle(1'b1, adr, 2'b01, b, unused);
    if (adr == 2'b10) last_cmd = b;
    else if (last_cmd == 8'h60) begin
      ctrl_byte = b;
      last_cmd  = 8'h00;
    end
  endtask

  task automatic read_data(input logic [1:0] sel);
    logic [7:0] got;
    exp_q.push_back(expected_data());
    bus_cycle(1'b0, 2'b00, sel, 8'h00, got);
    act_q.push_back(got);
    if (last_cmd inside {8'h20, 8'hAA, 8'hA9}) last_cmd = 8'h00;
    else if (mse_pend) mse_pend = 1'b0;
    else kbd_pend = 1'b0;
  endtask

  task automatic check_status();
    logic [7:0] got;
    bus_cycle(1'b0, 2'b10, 2'b01, 8'h00, got);
    compare_value(got, expected_status(), "status");
    err_flag = 1'b0;  // Error bit clears on this read
  endtask

  task automatic wait_irq(input logic mouse);
    int n = 0;
    while ((mouse ? wb_tgm_o : wb_tgk_o) !== 1'b1 && n < 16) begin
      @(negedge wb_clk_i);
      n++;
    end
    if ((mouse ? wb_tgm_o : wb_tgk_o) !== 1'b1) begin
      other_errors++;
      $display("The %s interrupt did not rise", mouse ? "mouse" : "keyboard");
    end
  endtask

  // ----------------------------------------------------------------------
  // PS/2 frame driver
  // ----------------------------------------------------------------------
  task automatic set_line(input logic mouse, input logic clk, input logic dat);
    if (mouse) {ps2_mse_clk_i, ps2_mse_dat_i} = {clk, dat};
    else       {ps2_kbd_clk_i, ps2_kbd_dat_i} = {clk, dat};
  endtask

  // Each line bit sits 4 cycles with the clock high and 4 with it low
  task automatic send_frame(input logic mouse, input logic [7:0] b, input logic bad_par);
    logic [10:0] bits;
    bits = {1'b1, (~^b) ^ bad_par, b, 1'b0};  // Stop, odd parity, data, start
    @(negedge wb_clk_i);
    for (int i = 0; i < ps2_pkg::FRAME_BITS; i++) begin
      set_line(mouse, 1'b1, bits[i]);
      repeat (4) @(negedge wb_clk_i);
      set_line(mouse, 1'b0, bits[i]);
      repeat (4) @(negedge wb_clk_i);
    end
    set_line(mouse, 1'b1, 1'b1);
    // Full buffer turns a good frame into an overrun
    if (bad_par || (mouse ? mse_pend : kbd_pend)) err_flag = 1'b1;
    else if (mouse) {mse_pend, mse_byte} = {1'b1, b};
    else {kbd_pend, kbd_byte} = {1'b1, b};
  endtask

  // Compare every data read against the model
  always @(posedge wb_clk_i) begin : compare_reads
    logic [7:0] got;
    logic [7:0] want;
    if (act_q.size() > 0) begin
      got  = act_q.pop_front();
      want = exp_q.pop_front();
      if (got !== want) begin
        data_errors++;
        $display("[ERROR] %0t ns: data port read %02h, expected %02h", $time, got, want);
      end
    end
  end

  always @(posedge wb_clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      print_counts();
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    logic [7:0] kb;
    logic [7:0] mb;
    wb_rst_i = 1'b1;
    wb_dat_i = '0;
    {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
    wb_adr_i = 2'b00;
    wb_sel_i = 2'b01;
    {ps2_kbd_clk_i, ps2_kbd_dat_i, ps2_mse_clk_i, ps2_mse_dat_i} = 4'hF;  // Idle lines
    {kbd_pend, mse_pend, err_flag} = 3'b000;
    {kbd_byte, mse_byte, last_cmd} = '0;
    ctrl_byte = 8'h47;
    repeat (10) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    wb_rst_i = 1'b0;

    compare_value({6'd0, wb_tgm_o, wb_tgk_o}, 8'h00, "interrupts after reset");
    check_status();
    write_port(2'b10, 8'h20);
    read_data(2'b01);

    // Keyboard bytes through lane 0 then lane 1
    for (int lane = 0; lane < 2; lane++) begin
      kb = $random(seed);
      send_frame(1'b0, kb, 1'b0);
      wait_irq(1'b0);
      check_status();
      read_data(lane == 0 ? 2'b01 : 2'b00);
      compare_value({7'd0, wb_tgk_o}, 8'h00, "keyboard interrupt after read");
      check_status();
    end

    kb = $random(seed);
    mb = $random(seed);
    fork
      send_frame(1'b0, kb, 1'b0);
      send_frame(1'b1, mb, 1'b0);
    join
    wait_irq(1'b1);
    wait_irq(1'b0);
    check_status();
    read_data(2'b01);  // Mouse comes out first
    compare_value({7'd0, wb_tgm_o}, 8'h00, "mouse interrupt after read");
    check_status();
    read_data(2'b00);
    check_status();

    // Interrupts off then the test commands
    write_port(2'b10, 8'h60);
    write_port(2'b00, 8'h44);
    write_port(2'b10, 8'h20);
    read_data(2'b01);
    kb = $random(seed);
    mb = $random(seed);
    fork
      send_frame(1'b0, kb, 1'b0);
      send_frame(1'b1, mb, 1'b0);
    join
    compare_value({6'd0, wb_tgm_o, wb_tgk_o}, 8'h00, "interrupts while disabled");
    check_status();
    write_port(2'b10, 8'hAA);
    read_data(2'b01);
    write_port(2'b10, 8'hA9);
    read_data(2'b01);
    read_data(2'b01);
    read_data(2'b01);
    check_status();

    // Parity fault then a mouse overrun
    kb = $random(seed);
    send_frame(1'b0, kb, 1'b1);
    check_status();
    check_status();
    mb = $random(seed);
    send_frame(1'b1, mb, 1'b0);
    kb = $random(seed);
    send_frame(1'b1, kb, 1'b0);
    check_status();
    check_status();
    read_data(2'b01);
    check_status();

    repeat (2) @(negedge wb_clk_i);  // Let the last compare run
    print_counts();
    if (data_errors + other_errors + assert_errors == 0) $display("=== PASS ===");
    else $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/ps2_rx_props.sv
// Credit and marker rules of the PS/2 receiver as concurrent assertions
`timescale 1ns/1ps
`default_nettype none

module ps2_rx_props (
  input logic                            wb_clk_i,
  input logic                            wb_rst_i,
  input logic                            credit_i,  // Host returns a buffer
  input logic [ps2_pkg::RX_CREDIT_W-1:0] credit_q,  // Free host buffers
  input ps2_pkg::rx_byte_t               rx_o
);

  int fails = 0;  // Failed assertion count

  // A delivered byte spends a credit held on the edge before
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                   rx_o.valid |-> $past(credit_q) != 0)
    else begin
      fails++;
      $error("Byte delivered without a credit");
    end

  // A credit comes back only while one is spent
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                   credit_i |-> credit_q < ps2_pkg::RX_CREDITS)
    else begin
      fails++;
      $error("Credit count above the host buffer count");
    end

  // Delivery and fault are exclusive
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                   !(rx_o.valid && rx_o.err))
    else begin
      fails++;
      $error("Valid and error markers high together");
    end

endmodule

bind ps2_rx ps2_rx_props u_props (
  .wb_clk_i (wb_clk_i),
  .wb_rst_i (wb_rst_i),
  .credit_i (credit_i),
  .credit_q (credit_q),
  .rx_o     (rx_o)
);

`default_nettype wire

// File: verilog/ps2_kbc.sv
// PS/2 keyboard and mouse controller top with two receivers and the host block
`timescale 1ns/1ps
`default_nettype none

module ps2_kbc (
  input  logic                         wb_clk_i,       // System clock
  input  logic                         wb_rst_i,       // Async reset, active high
  input  logic [kbc_pkg::WB_DATA_W-1:0] wb_dat_i,      // Write data
  output logic [kbc_pkg::WB_DATA_W-1:0] wb_dat_o,      // Read data
  input  logic                         wb_cyc_i,       // Bus cycle
  input  logic                         wb_stb_i,       // Strobe
  input  logic [2:1]                   wb_adr_i,       // Word address
  input  logic [1:0]                   wb_sel_i,       // Byte lanes
  input  logic                         wb_we_i,        // Write enable
  output logic                         wb_ack_o,       // Same cycle ack
  output logic                         wb_tgk_o,       // Keyboard interrupt
  output logic                         wb_tgm_o,       // Mouse interrupt
  input  logic                         ps2_kbd_clk_i,  // Keyboard line clock
  input  logic                         ps2_kbd_dat_i,  // Keyboard line data
  input  logic                         ps2_mse_clk_i,  // Mouse line clock
  input  logic                         ps2_mse_dat_i   // Mouse line data
);

  // ----------------------------------------------------------------------
  // Receiver to host byte paths, one credit each
  // ----------------------------------------------------------------------
  ps2_pkg::rx_byte_t kbd_rx;
  ps2_pkg::rx_byte_t mse_rx;
  logic              kbd_credit;
  logic              mse_credit;

  ps2_rx u_kbd_rx (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .ps2_clk_i (ps2_kbd_clk_i),
    .ps2_dat_i (ps2_kbd_dat_i),
    .credit_i  (kbd_credit),
    .rx_o      (kbd_rx)
  );

  ps2_rx u_mse_rx (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .ps2_clk_i (ps2_mse_clk_i),
    .ps2_dat_i (ps2_mse_dat_i),
    .credit_i  (mse_credit),
    .rx_o      (mse_rx)
  );

  // Register front end
  kbc_host u_host (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_dat_i     (wb_dat_i),
    .wb_adr_i     (wb_adr_i),
    .wb_sel_i     (wb_sel_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_tgk_o     (wb_tgk_o),
    .wb_tgm_o     (wb_tgm_o),
    .kbd_rx_i     (kbd_rx),
    .mse_rx_i     (mse_rx),
    .kbd_credit_o (kbd_credit),
    .mse_credit_o (mse_credit)
  );

endmodule

`default_nettype wire

// File: verilog/kbc_host.sv
// 8042 style host block with Wishbone ports 0x60 and 0x64, buffers and interrupts
`timescale 1ns/1ps
`default_nettype none

module kbc_host (
  input  logic                         wb_clk_i,      // System clock
  input  logic                         wb_rst_i,      // Async reset, active high
  input  logic [kbc_pkg::WB_DATA_W-1:0] wb_dat_i,     // Write data, two lanes
  input  logic [2:1]                   wb_adr_i,      // Word address
  input  logic [1:0]                   wb_sel_i,      // Byte lane select
  input  logic                         wb_we_i,       // Write enable
  input  logic                         wb_cyc_i,      // Bus cycle
  input  logic                         wb_stb_i,      // Strobe
  output logic [kbc_pkg::WB_DATA_W-1:0] wb_dat_o,     // Read data
  output logic                         wb_ack_o,      // Same cycle ack
  output logic                         wb_tgk_o,      // Keyboard interrupt
  output logic                         wb_tgm_o,      // Mouse interrupt
  input  ps2_pkg::rx_byte_t            kbd_rx_i,      // Keyboard receiver
  input  ps2_pkg::rx_byte_t            mse_rx_i,      // Mouse receiver
  output logic                         kbd_credit_o,  // Keyboard buffer freed
  output logic                         mse_credit_o   // Mouse buffer freed
);

  // ----------------------------------------------------------------------
  // Lane and port decode
  // ----------------------------------------------------------------------
  logic [7:0]        dat_byte;  // Write byte from the selected lane
  logic [2:0]        port;
  logic              acc_wr;
  logic              acc_rd;
  logic              dat_wr;
  logic              dat_rd;
  logic              cmd_wr;
  logic              stat_rd;
  kbc_pkg::kbc_cmd_e cmd;

  assign dat_byte = wb_sel_i[0] ? wb_dat_i[7:0] : wb_dat_i[15:8];
  assign port     = {wb_adr_i, wb_sel_i[1]};
  assign wb_ack_o = wb_stb_i & wb_cyc_i;  // No wait states
  assign acc_wr   = wb_ack_o & wb_we_i;
  assign acc_rd   = wb_ack_o & ~wb_we_i;
  assign dat_wr   = acc_wr && (port == kbc_pkg::PORT_DATA);
  assign dat_rd   = acc_rd && (port == kbc_pkg::PORT_DATA);
  assign cmd_wr   = acc_wr && (port == kbc_pkg::PORT_CMD);
  assign stat_rd  = acc_rd && (port == kbc_pkg::PORT_CMD);
  assign cmd      = kbc_pkg::kbc_cmd_e'(dat_byte);  // Other opcodes match nothing

  // ----------------------------------------------------------------------
  // Control byte and one-shot command flags
  // ----------------------------------------------------------------------
  kbc_pkg::kbc_ctrl_t ctrl_q;
  logic               rd_ctrl_q;    // Next data read returns ctrl_q
  logic               wr_ctrl_q;    // Next data write loads ctrl_q
  logic               self_test_q;  // Next data read returns 0x55
  logic               mse_test_q;   // Next data read returns 0x00
  logic               flag_rd;      // Data read answered by a flag

  assign flag_rd = rd_ctrl_q | self_test_q | mse_test_q;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ctrl_q      <= kbc_pkg::CTRL_RESET;
      rd_ctrl_q   <= 1'b0;
      wr_ctrl_q   <= 1'b0;
      self_test_q <= 1'b0;
      mse_test_q  <= 1'b0;
    end else begin
      if (cmd_wr) begin
        case (cmd)
          kbc_pkg::CMD_RD_CTRL:   rd_ctrl_q   <= 1'b1;
          kbc_pkg::CMD_WR_CTRL:   wr_ctrl_q   <= 1'b1;
          kbc_pkg::CMD_SELF_TEST: self_test_q <= 1'b1;
          kbc_pkg::CMD_MSE_TEST:  mse_test_q  <= 1'b1;
          default: ;  // Unsupported, ignored
        endcase
      end
      if (dat_wr && wr_ctrl_q) begin
        ctrl_q    <= kbc_pkg::kbc_ctrl_t'(dat_byte);
        wr_ctrl_q <= 1'b0;
      end
      // Only the flag that answered the read is cleared
      if (dat_rd) begin
        if (rd_ctrl_q)        rd_ctrl_q   <= 1'b0;
        else if (self_test_q) self_test_q <= 1'b0;
        else if (mse_test_q)  mse_test_q  <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Byte buffers, pending flags and credit return
  // ----------------------------------------------------------------------
  logic [7:0] kbd_buf_q;
  logic [7:0] mse_buf_q;
  logic       kbd_pend_q;
  logic       mse_pend_q;
  logic       byte_rd;   // Data read served from a buffer
  logic       mse_take;  // Mouse wins when both are pending
  logic       kbd_take;
  logic       err_q;     // Sticky receive fault

  assign byte_rd  = dat_rd & ~flag_rd;
  assign mse_take = byte_rd & mse_pend_q;
  assign kbd_take = byte_rd & ~mse_pend_q & kbd_pend_q;

  always_ff @(posedge wb_clk_i) begin
    if (kbd_rx_i.valid) kbd_buf_q <= kbd_rx_i.data;
    if (mse_rx_i.valid) mse_buf_q <= mse_rx_i.data;
  end

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      kbd_pend_q   <= 1'b0;
      mse_pend_q   <= 1'b0;
      kbd_credit_o <= 1'b0;
      mse_credit_o <= 1'b0;
      err_q        <= 1'b0;
    end else begin
      kbd_credit_o <= kbd_take;  // Cycle after the read
      mse_credit_o <= mse_take;
      if (kbd_take)       kbd_pend_q <= 1'b0;
      if (mse_take)       mse_pend_q <= 1'b0;
      if (kbd_rx_i.valid) kbd_pend_q <= 1'b1;
      if (mse_rx_i.valid) mse_pend_q <= 1'b1;
      if (stat_rd) err_q <= 1'b0;
      if (kbd_rx_i.err || mse_rx_i.err) err_q <= 1'b1;  // New fault beats the clear
    end
  end

  // ----------------------------------------------------------------------
  // Status, read mux and interrupts
  // ----------------------------------------------------------------------
  kbc_pkg::kbc_stat_t stat;
  logic [7:0]         data_byte;
  logic [7:0]         rd_byte;

  always_comb begin
    stat         = '0;  // obf, a2 and timeout stay low
    stat.ibf     = kbd_pend_q | mse_pend_q | flag_rd;
    stat.sys     = 1'b1;
    stat.inh     = 1'b1;
    stat.mobf    = mse_pend_q;
    stat.error   = err_q;
  end

  always_comb begin
    if (rd_ctrl_q)        data_byte = ctrl_q;
    else if (self_test_q) data_byte = kbc_pkg::SELF_TEST_OK;
    else if (mse_test_q)  data_byte = kbc_pkg::MSE_TEST_OK;
    else if (mse_pend_q)  data_byte = mse_buf_q;  // Mouse first
    else                  data_byte = kbd_buf_q;
  end

  assign rd_byte  = (port == kbc_pkg::PORT_DATA) ? data_byte : stat;
  assign wb_dat_o = wb_sel_i[0] ? {8'h00, rd_byte} : {rd_byte, 8'h00};

  assign wb_tgk_o = kbd_pend_q & ctrl_q.kbd_int_en;  // Level, until the byte is read
  assign wb_tgm_o = mse_pend_q & ctrl_q.mse_int_en;

endmodule

`default_nettype wire

// File: verilog/ps2_rx.sv
// PS/2 frame receiver with line synchronizers, parity check and credit counter
`timescale 1ns/1ps
`default_nettype none

module ps2_rx (
  input  logic               wb_clk_i,   // System clock
  input  logic               wb_rst_i,   // Active high async reset
  input  logic               ps2_clk_i,  // Asynchronous device clock
  input  logic               ps2_dat_i,  // Asynchronous device data
  input  logic               credit_i,   // Host freed its buffer
  output ps2_pkg::rx_byte_t  rx_o        // Byte and fault markers
);

  // ----------------------------------------------------------------------
  // Line synchronizers and falling edge detect
  // ----------------------------------------------------------------------
  logic [1:0] clk_sync_q;  // Two stages on the line clock
  logic [1:0] dat_sync_q;  // Two stages on the line data with the same delay
  logic       clk_prev_q;  // Synchronized clock one cycle back
  logic       clk_fall;    // Line clock went low
  logic       dat_s;       // Synchronized data

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      clk_sync_q <= 2'b11;  // Idle line is high
      dat_sync_q <= 2'b11;
      clk_prev_q <= 1'b1;
    end else begin
      clk_sync_q <= {clk_sync_q[0], ps2_clk_i};
      dat_sync_q <= {dat_sync_q[0], ps2_dat_i};
      clk_prev_q <= clk_sync_q[1];
    end
  end

  assign clk_fall = clk_prev_q & ~clk_sync_q[1];  // High right after the second stage
  assign dat_s    = dat_sync_q[1];

  // ----------------------------------------------------------------------
  // Frame FSM
  // ----------------------------------------------------------------------
  ps2_pkg::rx_state_e state_q;
  logic [2:0]         bit_cnt_q;  // Data bit index 0 .. 7
  logic [7:0]         shift_q;    // Data bits with the LSB entering first at the top
  logic               par_q;      // Received parity bit
  logic               frame_end;  // Stop bit edge seen
  logic               frame_ok;   // Odd parity and stop high
  logic               have_credit;
  logic               deliver;    // Good byte and a free host buffer
  logic               valid_q;
  logic               err_q;

  logic [ps2_pkg::RX_CREDIT_W-1:0] credit_q;  // Free host buffers

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state_q   <= ps2_pkg::RX_IDLE;
      bit_cnt_q <= 3'd0;
    end else if (clk_fall) begin
      case (state_q)
        ps2_pkg::RX_IDLE: begin
          if (!dat_s) begin  // Start bit
            state_q   <= ps2_pkg::RX_DATA;
            bit_cnt_q <= 3'd0;
          end
        end
        ps2_pkg::RX_DATA: begin
          bit_cnt_q <= bit_cnt_q + 3'd1;
          // Last data bit is the frame minus start, parity and stop
          if (bit_cnt_q == 3'(ps2_pkg::FRAME_BITS - 4)) state_q <= ps2_pkg::RX_PARITY;
        end
        ps2_pkg::RX_PARITY: state_q <= ps2_pkg::RX_STOP;
        ps2_pkg::RX_STOP:   state_q <= ps2_pkg::RX_IDLE;  // Ready for the next start bit
        default:            state_q <= ps2_pkg::RX_IDLE;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge wb_clk_i) begin
    if (clk_fall && state_q == ps2_pkg::RX_DATA) shift_q <= {dat_s, shift_q[7:1]};
    if (clk_fall && state_q == ps2_pkg::RX_PARITY) par_q <= dat_s;
  end

  assign frame_end   = clk_fall && (state_q == ps2_pkg::RX_STOP);
  assign frame_ok    = frame_end & dat_s & (^{shift_q, par_q});  // Odd count of ones
  assign have_credit = (credit_q != '0);
  assign deliver     = frame_ok & have_credit;

  // ----------------------------------------------------------------------
  // Credit counter and output markers
  // ----------------------------------------------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      credit_q <= ps2_pkg::RX_CREDIT_W'(ps2_pkg::RX_CREDITS);  // Host buffer starts empty
      valid_q  <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      valid_q <= deliver;
      err_q   <= frame_end & ~deliver;  // Bad frame or good one with no room
      if (deliver && !credit_i) begin
        credit_q <= credit_q - 1'b1;  // Byte now sits in the host
      end else if (credit_i && !deliver &&
                   credit_q < ps2_pkg::RX_CREDIT_W'(ps2_pkg::RX_CREDITS)) begin
        credit_q <= credit_q + 1'b1;  // Host read it back out
      end
    end
  end

  assign rx_o.valid = valid_q;
  assign rx_o.data  = shift_q;  // Held until the next frame starts shifting
  assign rx_o.err   = err_q;

endmodule

`default_nettype wire

// File: verilog/kbc_pkg.sv
// Keyboard controller definitions for ports, commands, control and status bytes
`default_nettype none

package kbc_pkg;

  // ----------------------------------------------------------------------
  // Bus and port decoding
  // ----------------------------------------------------------------------
  localparam int WB_DATA_W = 16;  // Wishbone data width, two byte lanes

  // Decoded address is {wb_adr_i, wb_sel_i[1]}
  localparam logic [2:0] PORT_DATA = 3'b000;  // Port 0x60, data in and out
  localparam logic [2:0] PORT_CMD  = 3'b100;  // Port 0x64, status read, command write

  // ----------------------------------------------------------------------
  // Controller commands written to port 0x64
  // ----------------------------------------------------------------------
  typedef enum logic [7:0] {
    CMD_RD_CTRL   = 8'h20,  // Next data read returns the control byte
    CMD_WR_CTRL   = 8'h60,  // Next data write loads the control byte
    CMD_MSE_TEST  = 8'hA9,  // Mouse interface test
    CMD_SELF_TEST = 8'hAA   // Controller self-test
  } kbc_cmd_e;

  // Control byte, only the interrupt enables drive logic here
  typedef struct packed {
    logic rsvd7;       // Unassigned
    logic xlat;        // Scan code translation
    logic mse_dis;     // Mouse interface disable
    logic kbd_dis;     // Keyboard interface disable
    logic rsvd3;       // Unassigned
    logic sys_flag;    // System flag
    logic mse_int_en;  // Mouse interrupt enable
    logic kbd_int_en;  // Keyboard interrupt enable
  } kbc_ctrl_t;

  // Status byte read from port 0x64
  typedef struct packed {
    logic error;    // Sticky receive fault
    logic timeout;  // No transmitter, always 0
    logic mobf;     // Mouse byte pending
    logic inh;      // Not inhibited
    logic a2;       // Last written port
    logic sys;      // System initialized
    logic obf;      // No transmitter, always 0
    logic ibf;      // Something to read at port 0x60
  } kbc_stat_t;

  // ----------------------------------------------------------------------
  // Reset value and command replies
  // ----------------------------------------------------------------------
  localparam kbc_ctrl_t  CTRL_RESET   = 8'h47;  // Both interrupts on, sys, xlat
  localparam logic [7:0] SELF_TEST_OK = 8'h55;  // Self-test passed
  localparam logic [7:0] MSE_TEST_OK  = 8'h00;  // Mouse lines fine

endpackage

`default_nettype wire

// File: verilog/ps2_pkg.sv
// PS/2 line protocol definitions shared by the receivers and the host
`default_nettype none

package ps2_pkg;

  // ----------------------------------------------------------------------
  // Frame layout
  // ----------------------------------------------------------------------
  // One frame on the line, in order of the falling clock edges:
  //   start (0), d0 .. d7 (LSB first), odd parity, stop (1)
  localparam int FRAME_BITS = 11;        // Line bits per frame

  // ----------------------------------------------------------------------
  // Flow control toward the host
  // ----------------------------------------------------------------------
  localparam int RX_CREDITS  = 1;                       // Host buffers per channel
  localparam int RX_CREDIT_W = $clog2(RX_CREDITS + 1);  // Width of the credit count

  // Receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE   = 2'd0,  // Waiting for the start bit
    RX_DATA   = 2'd1,  // Shifting d0 .. d7
    RX_PARITY = 2'd2,  // Next edge carries the parity bit
    RX_STOP   = 2'd3   // Next edge carries the stop bit
  } rx_state_e;

  // Byte handed from a receiver to the host
  typedef struct packed {
    logic       valid;  // One cycle, good byte delivered
    logic [7:0] data;   // Received byte
    logic       err;    // One cycle, parity, stop or overrun fault
  } rx_byte_t;

endpackage

`default_nettype wire
